//--- design/sdram_addr_pkg.sv
package sdram_addr_pkg;

    typedef logic [22:0] user_addr_t; // {row, bank, column word}
    typedef logic [12:0] row_t;
    typedef logic [1:0]  bank_t;
    typedef logic [7:0]  col_t;       // word column, byte column is {col, 2'b00}
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    typedef struct packed {
        logic       rw;   // 1 = write
        user_addr_t addr;
        word_t      data;
    } mem_req_t;

    function automatic row_t addr_row(input user_addr_t a);
        return a[22:10];
    endfunction

    function automatic bank_t addr_bank(input user_addr_t a);
        return a[9:8];
    endfunction

    function automatic col_t addr_col(input user_addr_t a);
        return a[7:0];
    endfunction

endpackage

//--- design/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

    // command bits are {cs, ras, cas, we}, all active low on the device
    typedef logic [3:0] sdram_cmd_t;

    localparam sdram_cmd_t CMD_NOP       = 4'b0111;
    localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
    localparam sdram_cmd_t CMD_READ      = 4'b0101;
    localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
    localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
    localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
    localparam sdram_cmd_t CMD_LOAD_MODE = 4'b0000;

    // reserved, burst access, standard op, cas 2, sequential, burst 4
    localparam logic [12:0] MODE_REG_VALUE = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b010};

    // NOP cycles between a command and the next step
    localparam int T_RP_WAIT  = 1; // precharge to next command
    localparam int T_RCD_WAIT = 1; // active to read/write
    localparam int T_RFC_WAIT = 7; // refresh to next command
    localparam int CAS_WAIT   = 2; // read to first data byte

    typedef struct packed {
        logic        cke;
        sdram_cmd_t  cmd;
        logic [1:0]  ba;
        logic [12:0] a;
    } pin_cmd_t;

    typedef struct packed {
        logic       oe;      // drive dq this cycle
        logic [7:0] wbyte;
        logic       capture; // read byte expected on dq
        logic       last;    // final byte of the burst
    } dq_ctl_t;

endpackage

//--- design/sdram_ctrl_top.sv
`timescale 1ns/100ps

module sdram_ctrl_top #(
    parameter int init_cycles    = 10100,
    parameter int refresh_cycles = 750
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  sdram_addr_pkg::user_addr_t addr,
    input  logic                       rw,
    input  sdram_addr_pkg::word_t      data_in,
    output sdram_addr_pkg::word_t      data_out,
    output logic                       busy,
    output logic                       out_valid,
    output logic                       sdram_cke,
    output logic                       sdram_cs,
    output logic                       sdram_ras,
    output logic                       sdram_cas,
    output logic                       sdram_we,
    output sdram_addr_pkg::bank_t      sdram_ba,
    output sdram_addr_pkg::row_t       sdram_a,
    output sdram_addr_pkg::byte_t      dq_out,
    output logic                       dq_oe,
    input  sdram_addr_pkg::byte_t      dq_in
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    mem_req_t held_req;
    logic     held;
    logic     take;
    logic     init_done;
    logic     refresh_req;
    logic     refresh_ack;
    pin_cmd_t pin_cmd;
    dq_ctl_t  dq_ctl;

    sdram_req_queue req_queue_inst (
        .clk, .rst, .in_valid, .addr, .rw, .data_in,
        .init_done, .take, .held_req, .held, .busy
    );

    sdram_refresh_timer #(
        .refresh_cycles(refresh_cycles)
    ) refresh_timer_inst (
        .clk, .rst,
        .run        (init_done), // no refresh before the mode load
        .refresh_ack,
        .refresh_req
    );

    sdram_sequencer #(
        .init_cycles(init_cycles)
    ) sequencer_inst (
        .clk, .rst, .held_req, .held, .take, .refresh_req, .refresh_ack,
        .init_done, .pin_cmd, .dq_ctl
    );

    sdram_pad_regs pad_regs_inst (
        .clk, .rst, .pin_cmd, .dq_ctl,
        .sdram_cke, .sdram_cs, .sdram_ras, .sdram_cas, .sdram_we,
        .sdram_ba, .sdram_a, .dq_out, .dq_oe, .dq_in, .data_out, .out_valid
    );

endmodule

//--- design/sdram_pad_regs.sv
`timescale 1ns/100ps

module sdram_pad_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  sdram_cmd_pkg::pin_cmd_t pin_cmd,
    input  sdram_cmd_pkg::dq_ctl_t  dq_ctl,
    output logic                    sdram_cke,
    output logic                    sdram_cs,
    output logic                    sdram_ras,
    output logic                    sdram_cas,
    output logic                    sdram_we,
    output sdram_addr_pkg::bank_t   sdram_ba,
    output sdram_addr_pkg::row_t    sdram_a,
    output sdram_addr_pkg::byte_t   dq_out,
    output logic                    dq_oe,
    input  sdram_addr_pkg::byte_t   dq_in,
    output sdram_addr_pkg::word_t   data_out,
    output logic                    out_valid
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    sdram_cmd_t cmd_q;
    byte_t      dqi_q;
    logic       capture_q;
    logic       last_q;
    word_t      word_q;

    assign sdram_cs  = cmd_q[3];
    assign sdram_ras = cmd_q[2];
    assign sdram_cas = cmd_q[1];
    assign sdram_we  = cmd_q[0];
    assign data_out  = word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sdram_cke <= 1'b0;
            cmd_q     <= CMD_NOP;
            dq_oe     <= 1'b0;
            capture_q <= 1'b0;
            last_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            sdram_cke <= pin_cmd.cke;
            cmd_q     <= pin_cmd.cmd;
            dq_oe     <= dq_ctl.oe;
            capture_q <= dq_ctl.capture; // lines up with dqi_q
            last_q    <= dq_ctl.last;
            out_valid <= last_q;         // word complete after last shift
        end
    end

    // address, write data and input byte
    always_ff @(posedge clk) begin
        sdram_ba <= pin_cmd.ba;
        sdram_a  <= pin_cmd.a;
        dq_out   <= dq_ctl.wbyte;
        dqi_q    <= dq_in;
    end

    // shift in from the top so the first byte ends up lowest
    always_ff @(posedge clk) begin
        if (capture_q) begin
            word_q <= {dqi_q, word_q[31:8]};
        end
    end

endmodule

//--- design/sdram_refresh_timer.sv
`timescale 1ns/100ps

module sdram_refresh_timer #(
    parameter int refresh_cycles = 750
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic refresh_ack,
    output logic refresh_req
);
    localparam int CNT_W = $clog2(refresh_cycles + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    localparam cnt_t CNT_LAST = cnt_t'(refresh_cycles - 1);

    cnt_t cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            refresh_req <= 1'b0;
        end else if (refresh_ack) begin
            cnt         <= '0; // restart the interval
            refresh_req <= 1'b0;
        end else if (run && !refresh_req) begin
            if (cnt == CNT_LAST) begin
                refresh_req <= 1'b1; // held until the ack
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/sdram_req_queue.sv
`timescale 1ns/100ps

module sdram_req_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  sdram_addr_pkg::user_addr_t addr,
    input  logic                     rw,
    input  sdram_addr_pkg::word_t    data_in,
    input  logic                     init_done,
    input  logic                     take,
    output sdram_addr_pkg::mem_req_t held_req,
    output logic                     held,
    output logic                     busy
);
    import sdram_addr_pkg::*;

    logic accept;

    assign busy   = held | ~init_done;
    assign accept = in_valid & ~busy; // requests while busy are dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (take) begin
            held <= 1'b0; // sequencer started it
        end else if (accept) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= mem_req_t'{rw: rw, addr: addr, data: data_in};
        end
    end

endmodule

//--- design/sdram_sequencer.sv
`timescale 1ns/100ps

module sdram_sequencer #(
    parameter int init_cycles = 10100
) (
    input  logic                     clk,
    input  logic                     rst,
    input  sdram_addr_pkg::mem_req_t held_req,
    input  logic                     held,
    output logic                     take,
    input  logic                     refresh_req,
    output logic                     refresh_ack,
    output logic                     init_done,
    output sdram_cmd_pkg::pin_cmd_t  pin_cmd,
    output sdram_cmd_pkg::dq_ctl_t   dq_ctl
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    localparam int DELAY_W    = $clog2(init_cycles + 1);
    localparam int T_MRD_WAIT = 2; // mode register set to first command

    typedef logic [DELAY_W-1:0] delay_t;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_WAIT,
        ST_PRECHARGE_INIT,
        ST_REFRESH_INIT_1,
        ST_REFRESH_INIT_2,
        ST_LOAD_MODE,
        ST_IDLE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_READ_RES,
        ST_WRITE,
        ST_PRECHARGE
    } state_t;

    state_t     state;
    state_t     next_state; // where ST_WAIT returns to
    delay_t     delay;
    logic [1:0] byte_cnt;
    mem_req_t   cur_req;
    logic [3:0] row_open;
    row_t       open_row [4];
    logic       pre_all;

    bank_t held_bank;
    row_t  held_row;
    bank_t cur_bank;
    row_t  cur_row;
    col_t  cur_col;
    logic  start;

    assign held_bank = addr_bank(held_req.addr);
    assign held_row  = addr_row(held_req.addr);
    assign cur_bank  = addr_bank(cur_req.addr);
    assign cur_row   = addr_row(cur_req.addr);
    assign cur_col   = addr_col(cur_req.addr);

    // refresh wins over a waiting request
    assign start = (state == ST_IDLE) && !refresh_req && held;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_INIT;
            init_done <= 1'b0;
            row_open  <= '0;
            byte_cnt  <= '0;
            pre_all   <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    delay      <= delay_t'(init_cycles - 1);
                    next_state <= ST_PRECHARGE_INIT;
                    state      <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (delay == '0) begin
                        state <= next_state;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                ST_PRECHARGE_INIT: begin
                    row_open   <= '0;
                    delay      <= delay_t'(T_RP_WAIT - 1);
                    next_state <= ST_REFRESH_INIT_1;
                    state      <= ST_WAIT;
                end
                ST_REFRESH_INIT_1: begin
                    delay      <= delay_t'(T_RFC_WAIT - 1);
                    next_state <= ST_REFRESH_INIT_2;
                    state      <= ST_WAIT;
                end
                ST_REFRESH_INIT_2: begin
                    delay      <= delay_t'(T_RFC_WAIT - 1);
                    next_state <= ST_LOAD_MODE;
                    state      <= ST_WAIT;
                end
                ST_LOAD_MODE: begin
                    init_done  <= 1'b1; // user side opens here
                    delay      <= delay_t'(T_MRD_WAIT - 1);
                    next_state <= ST_IDLE;
                    state      <= ST_WAIT;
                end
                ST_IDLE: begin
                    if (refresh_req) begin
                        pre_all    <= 1'b1;
                        next_state <= ST_REFRESH;
                        state      <= ST_PRECHARGE;
                    end else if (held) begin
                        cur_req <= held_req;
                        if (!row_open[held_bank]) begin
                            state <= ST_ACTIVATE; // bank closed
                        end else if (open_row[held_bank] == held_row) begin
                            state <= held_req.rw ? ST_WRITE : ST_READ; // row hit
                        end else begin
                            pre_all    <= 1'b0; // row miss, close this bank first
                            next_state <= ST_ACTIVATE;
                            state      <= ST_PRECHARGE;
                        end
                    end
                end
                ST_REFRESH: begin
                    delay      <= delay_t'(T_RFC_WAIT - 1);
                    next_state <= ST_IDLE;
                    state      <= ST_WAIT;
                end
                ST_ACTIVATE: begin
                    row_open[cur_bank] <= 1'b1;
                    open_row[cur_bank] <= cur_row;
                    delay              <= delay_t'(T_RCD_WAIT - 1);
                    next_state         <= cur_req.rw ? ST_WRITE : ST_READ;
                    state              <= ST_WAIT;
                end
                ST_READ: begin
                    delay      <= delay_t'(CAS_WAIT - 1);
                    next_state <= ST_READ_RES;
                    state      <= ST_WAIT;
                end
                ST_READ_RES: begin
                    byte_cnt <= byte_cnt + 1'b1; // wraps back to 0
                    if (byte_cnt == 2'd3) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    byte_cnt     <= byte_cnt + 1'b1;
                    cur_req.data <= {8'h00, cur_req.data[31:8]}; // next byte down
                    if (byte_cnt == 2'd3) begin
                        state <= ST_IDLE;
                    end
                end
                ST_PRECHARGE: begin
                    if (pre_all) begin
                        row_open <= '0;
                    end else begin
                        row_open[cur_bank] <= 1'b0;
                    end
                    delay <= delay_t'(T_RP_WAIT - 1);
                    state <= ST_WAIT;
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    always_comb begin
        pin_cmd     = '{cke: 1'b1, cmd: CMD_NOP, ba: '0, a: '0};
        dq_ctl      = '0;
        take        = start;
        refresh_ack = (state == ST_IDLE) && refresh_req;
        case (state)
            ST_PRECHARGE_INIT: begin
                pin_cmd.cmd   = CMD_PRECHARGE;
                pin_cmd.a[10] = 1'b1; // all banks
            end
            ST_REFRESH_INIT_1, ST_REFRESH_INIT_2, ST_REFRESH: begin
                pin_cmd.cmd = CMD_REFRESH;
            end
            ST_LOAD_MODE: begin
                pin_cmd.cmd = CMD_LOAD_MODE;
                pin_cmd.a   = MODE_REG_VALUE;
            end
            ST_ACTIVATE: begin
                pin_cmd.cmd = CMD_ACTIVE;
                pin_cmd.ba  = cur_bank;
                pin_cmd.a   = cur_row;
            end
            ST_READ: begin
                pin_cmd.cmd = CMD_READ;
                pin_cmd.ba  = cur_bank;
                pin_cmd.a   = {3'b000, cur_col, 2'b00}; // a10 low, no auto precharge
            end
            ST_READ_RES: begin
                dq_ctl.capture = 1'b1;
                dq_ctl.last    = (byte_cnt == 2'd3);
            end
            ST_WRITE: begin
                if (byte_cnt == 2'd0) begin
                    pin_cmd.cmd = CMD_WRITE; // burst carries the other three
                end
                pin_cmd.ba   = cur_bank;
                pin_cmd.a    = {3'b000, cur_col, 2'b00};
                dq_ctl.oe    = 1'b1;
                dq_ctl.wbyte = cur_req.data[7:0];
            end
            ST_PRECHARGE: begin
                pin_cmd.cmd   = CMD_PRECHARGE;
                pin_cmd.ba    = cur_bank;
                pin_cmd.a[10] = pre_all;
            end
            default: ;
        endcase
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl \
    -f tb.f -o sim_tb > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "TB FAILED" sim.log && { echo "failure found in sim.log"; exit 1; }
grep -q "TB PASSED" sim.log && echo "simulation passed" \
    || { echo "no pass verdict in sim.log"; exit 1; }

//--- tb.f
design/sdram_cmd_pkg.sv
design/sdram_addr_pkg.sv
design/sdram_req_queue.sv
design/sdram_refresh_timer.sv
design/sdram_sequencer.sv
design/sdram_pad_regs.sv
design/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/sdram_ctrl_asserts.sv
tb/tb_sdram_ctrl.sv

//--- tb/sdram_ctrl_asserts.sv
`timescale 1ns/100ps

module sdram_ctrl_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 busy,
    input logic                 out_valid,
    input logic                 dq_oe,
    input logic                 init_done,
    input logic                 sdram_cke,
    input logic                 sdram_cs,
    input logic                 sdram_ras,
    input logic                 sdram_cas,
    input logic                 sdram_we
);
    import sdram_cmd_pkg::*;

    sdram_cmd_t pin_cmd;
    logic       mode_loaded; // LOAD_MODE already left the pins

    assign pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_loaded <= 1'b0;
        end else if (pin_cmd == CMD_LOAD_MODE) begin
            mode_loaded <= 1'b1;
        end
    end

    out_valid_single: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles");

    no_drive_on_read: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd == CMD_READ) |-> !dq_oe)
        else $error("dq_oe high with READ on the pins");

    busy_before_mode: assert property (@(posedge clk) disable iff (rst)
        (!mode_loaded && pin_cmd != CMD_LOAD_MODE) |-> busy)
        else $error("busy low before the mode register load");

    cke_after_init: assert property (@(posedge clk) disable iff (rst)
        init_done |-> sdram_cke)
        else $error("cke dropped after init");

endmodule

bind sdram_ctrl_top sdram_ctrl_asserts ctrl_asserts_inst (.*);

//--- tb/sdram_model.sv
`timescale 1ns/100ps

module sdram_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cke,
    input  logic                  cs,
    input  logic                  ras,
    input  logic                  cas,
    input  logic                  we,
    input  sdram_addr_pkg::bank_t ba,
    input  sdram_addr_pkg::row_t  a,
    input  sdram_addr_pkg::byte_t dq_out,
    input  logic                  dq_oe,
    output sdram_addr_pkg::byte_t dq_in
);
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    typedef logic [24:0] cell_t; // {bank, row, byte column}

    byte_t      mem [cell_t];
    row_t       act_row [4];
    sdram_cmd_t cmd;
    cell_t      rd_base;
    cell_t      wr_base;
    int         rd_step; // next read byte, -1 when idle
    int         wr_step; // next write byte, -1 when idle
    logic       rd_active;
    byte_t      rd_byte;

    assign cmd   = {cs, ras, cas, we};
    assign dq_in = (rd_active === 1'b1) ? rd_byte : '0;

    // cells never written return a mix of all address bits
    function automatic byte_t cell_read(input cell_t c);
        if (mem.exists(c)) begin
            return mem[c];
        end
        return c[7:0] ^ c[15:8] ^ c[23:16] ^ {7'b0, c[24]};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rd_step   <= -1;
            wr_step   <= -1;
            rd_active <= 1'b0;
        end else begin
            rd_active <= 1'b0;
            if (rd_step >= 0) begin
                rd_active <= 1'b1;
                rd_byte   <= cell_read(rd_base + cell_t'(rd_step));
                rd_step   <= (rd_step == 3) ? -1 : rd_step + 1;
            end
            if (wr_step > 0 && dq_oe) begin
                mem[wr_base + cell_t'(wr_step)] = dq_out; // rest of the burst
                wr_step <= (wr_step == 3) ? -1 : wr_step + 1;
            end
            if (cke) begin
                case (cmd)
                    CMD_ACTIVE: act_row[ba] <= a;
                    CMD_READ: begin
                        rd_base <= {ba, act_row[ba], a[9:0]};
                        rd_step <= 0; // first byte after one more edge, CAS 2
                    end
                    CMD_WRITE: begin
                        mem[{ba, act_row[ba], a[9:0]}] = dq_out;
                        wr_base <= {ba, act_row[ba], a[9:0]};
                        wr_step <= 1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- tb/tb_sdram_ctrl.sv
`timescale 1ns/100ps

module tb_sdram_ctrl;
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;

    localparam int MAX_CYCLES = 20000; // init plus ~60 ops and the refresh idle

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       rw;
    user_addr_t addr;
    word_t      data_in;
    word_t      data_out;
    logic       busy;
    logic       out_valid;
    logic       sdram_cke;
    logic       sdram_cs;
    logic       sdram_ras;
    logic       sdram_cas;
    logic       sdram_we;
    bank_t      sdram_ba;
    row_t       sdram_a;
    byte_t      dq_out;
    byte_t      dq_in;
    logic       dq_oe;
    sdram_cmd_t pin_cmd;
    int         errors;
    int         cycles;
    int         refresh_count;
    logic       mode_seen;
    pin_cmd_t   cmd_log [$];    // non-NOP commands seen on the pins
    word_t      ref_mem [user_addr_t];

    assign pin_cmd = {sdram_cs, sdram_ras, sdram_cas, sdram_we};

    sdram_ctrl_top #(
        .init_cycles   (100),
        .refresh_cycles(300)
    ) sdram_ctrl_top_inst (.*);

    sdram_model mem_model (
        .clk, .rst, .cke(sdram_cke), .cs(sdram_cs), .ras(sdram_ras), .cas(sdram_cas),
        .we(sdram_we), .ba(sdram_ba), .a(sdram_a), .dq_out, .dq_oe, .dq_in
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // pin monitor, pins are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && pin_cmd != CMD_NOP) begin
            cmd_log.push_back('{cke: sdram_cke, cmd: pin_cmd, ba: sdram_ba, a: sdram_a});
        end
        if (pin_cmd == CMD_LOAD_MODE && sdram_a == MODE_REG_VALUE) begin
            mode_seen = 1'b1;
        end
        if (!rst && pin_cmd == CMD_REFRESH) begin
            refresh_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles, %0d errors", cycles, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // waits for busy low, then holds in_valid for one cycle
    task automatic issue(input logic w, input user_addr_t a, input word_t d);
        while (busy) @(negedge clk);
        in_valid = 1'b1;
        rw       = w;
        addr     = a;
        data_in  = d;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_word(input user_addr_t a, input word_t d);
        issue(1'b1, a, d);
        while (pin_cmd != CMD_WRITE) @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            check(pin_cmd, (i == 0) ? CMD_WRITE : CMD_NOP, "command during write burst");
            check(dq_oe, 1'b1, "dq_oe during write burst");
            check(dq_out, d[8*i +: 8], "write byte on dq_out");
            @(negedge clk);
        end
        ref_mem[a] = d;
    endtask

    task automatic read_check(input user_addr_t a);
        issue(1'b0, a, '0);
        while (!out_valid) @(negedge clk);
        check(data_out, ref_mem[a], "read data");
        @(negedge clk);
        check(out_valid, 1'b0, "out_valid second cycle");
    endtask

    task automatic reset_test();
        check(busy, 1'b1, "busy after reset");
        check(out_valid, 1'b0, "out_valid after reset");
        check(dq_oe, 1'b0, "dq_oe after reset");
        check(sdram_cke, 1'b0, "cke after reset");
        while (busy) @(negedge clk);
        @(negedge clk);
        check(mode_seen, 1'b1, "mode register load before busy fell");
    endtask

    task automatic write_read_test();
        write_word({13'h0042, 2'd2, 8'h05}, 32'ha1b2c3d4);
        read_check({13'h0042, 2'd2, 8'h05});
    endtask

    task automatic row_miss_test();
        int pre_at;
        int act_at;
        pre_at = -1;
        act_at = -1;
        write_word({13'h0123, 2'd1, 8'h10}, 32'h11223344);
        write_word({13'h0456, 2'd1, 8'h10}, 32'h55667788); // leaves row 0x456 open
        cmd_log.delete();
        read_check({13'h0123, 2'd1, 8'h10});
        foreach (cmd_log[i]) begin
            if (cmd_log[i].cmd == CMD_PRECHARGE && pre_at < 0) begin
                pre_at = i;
            end
            if (cmd_log[i].cmd == CMD_ACTIVE && cmd_log[i].ba == 2'd1
                    && cmd_log[i].a == 13'h0123) begin
                act_at = i;
            end
        end
        check(pre_at >= 0 && act_at > pre_at, 1'b1, "precharge then active on row miss");
        read_check({13'h0456, 2'd1, 8'h10});
    endtask

    task automatic refresh_test();
        int start;
        start = refresh_count;
        repeat (1000) @(negedge clk);
        check((refresh_count - start) >= 1000 / 300, 1'b1, "refreshes during idle");
        read_check({13'h0123, 2'd1, 8'h10});
        read_check({13'h0042, 2'd2, 8'h05});
    endtask

    task automatic random_test();
        user_addr_t addrs [$];
        user_addr_t a;
        int         idx;
        for (int i = 0; i < 20; i++) begin
            a = {13'($urandom), 2'(i), 8'($urandom)}; // walk all four banks
            addrs.push_back(a);
            write_word(a, $urandom);
        end
        while (addrs.size() > 0) begin
            idx = $urandom_range(addrs.size() - 1, 0);
            read_check(addrs[idx]);
            addrs.delete(idx);
        end
    endtask

    initial begin
        void'($urandom(16));
        errors        = 0;
        cycles        = 0;
        refresh_count = 0;
        mode_seen     = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        rw            = 1'b0;
        addr          = '0;
        data_in       = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        reset_test();
        write_read_test();
        row_miss_test();
        refresh_test();
        random_test();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
